//--- bench/dcache_tb.sv
// testbench for the two-way data cache
// replays operations from a data file against a next-level memory model
// with random grant delays, and checks data, hit timing and traffic

`default_nettype none

module dcache_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_addr_pkg::*;
  import cache_bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      bypass;
  core_req_t core_req;
  core_rsp_t core_rsp;
  mem_req_t  mem_req;
  logic      mem_gnt = 1'b0;
  mem_rsp_t  mem_rsp = '0;

  // next-level memory that stores only the written words
  word_t       mem_words [addr_t];
  logic [15:0] lfsr = 16'd63481;
  logic [1:0]  gnt_delay = '0;
  logic        gnt_armed = 1'b0;
  logic        rsp_pending = 1'b0;
  line_t       rsp_line = '0;

  // traffic seen by the model
  int   reads_seen = 0;
  int   writes_seen = 0;
  int   req_cycles = 0;
  logic last_bypass = 1'b0;

  // run bookkeeping
  int    cycle = 0;
  int    checks = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    test_ops = 0;
  int    test_errors = 0;
  string test_name = "none";
  logic  in_test = 1'b0;
  logic  hung = 1'b0;

  dcache_top DUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .bypass_i   (bypass),
    .core_req_i (core_req),
    .core_rsp_o (core_rsp),
    .mem_req_o  (mem_req),
    .mem_gnt_i  (mem_gnt),
    .mem_rsp_i  (mem_rsp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------
  // next-level memory model
  // ----------------------------------------
  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // untouched words hold their address above its inverse
  function automatic word_t mem_word(input addr_t a);
    if (mem_words.exists(a)) begin
      return mem_words[a];
    end
    return {a, ~a};
  endfunction

  // aligned line with word 0 in the low bits
  function automatic line_t mem_line(input addr_t a);
    line_t l;
    addr_t base;
    base = {a[15:4], 4'h0};
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = mem_word(base + addr_t'(w * 4));
    end
    return l;
  endfunction

  // act on a granted request
  task automatic serve_request(input mem_req_t req);
    addr_t a;
    word_t w;
    a = {req.addr[15:2], 2'b00};
    last_bypass = req.bypass;
    if (req.we) begin
      w = mem_word(a);
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) begin
          w[b*8 +: 8] = req.wdata[b*8 +: 8];
        end
      end
      mem_words[a] = w;
      writes_seen++;
    end else begin
      // line goes out one cycle after the grant
      rsp_line = mem_line(req.addr);
      rsp_pending = 1'b1;
      reads_seen++;
    end
  endtask

  // mem_req is registered in the DUT, so it is stable at the falling edge
  always @(negedge clk) begin
    mem_gnt = 1'b0;
    mem_rsp = '0;
    if (!rst_n) begin
      gnt_armed = 1'b0;
      rsp_pending = 1'b0;
    end else begin
      if (rsp_pending) begin
        mem_rsp.valid = 1'b1;
        mem_rsp.line  = rsp_line;
        rsp_pending   = 1'b0;
      end
      if (mem_req.valid) begin
        req_cycles++;
        // draw 0 to 3 wait cycles once per request
        if (!gnt_armed) begin
          gnt_delay = {lfsr_bit(), lfsr_bit()};
          gnt_armed = 1'b1;
        end
        if (gnt_delay == 2'd0) begin
          mem_gnt   = 1'b1;
          gnt_armed = 1'b0;
          serve_request(mem_req);
        end else begin
          gnt_delay = gnt_delay - 2'd1;
        end
      end
    end
  end

  // ----------------------------------------
  // checks and reporting
  // ----------------------------------------
  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act == exp) else begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
      errors++;
    end
  endtask

  task automatic report_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: %0d ops, ok", test_name, test_ops);
    end else begin
      $display("test %s: %0d ops, %0d errors", test_name, test_ops, test_errors);
    end
  endtask

  // ----------------------------------------
  // one core operation
  // ----------------------------------------
  // LM load miss, LH load hit, ST store, BL bypass load, BS bypass store
  task automatic run_op(input string op, input addr_t addr, input word_t wdata,
                        input be_t be, input word_t exp);
    int   waited;
    int   gnt_cycle;
    int   reads_before;
    int   writes_before;
    int   req_before;
    logic is_load;
    logic is_bypass;
    is_load       = (op == "LM") || (op == "LH") || (op == "BL");
    is_bypass     = (op == "BL") || (op == "BS");
    reads_before  = reads_seen;
    writes_before = writes_seen;
    req_before    = req_cycles;
    test_ops++;

    @(negedge clk);
    core_req.valid = 1'b1;
    core_req.we    = !is_load;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    core_req.be    = is_load ? be_t'('0) : be;
    bypass         = is_bypass;

    // sample one ns after the drive edge and well before the rising edge
    #1;
    waited = 0;
    while (!core_rsp.gnt && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!core_rsp.gnt) begin
      $display("%s: %s at %h got no grant in %0d cycles", test_name, op, addr,
               TIMEOUT_CYCLES);
      test_errors++;
      errors++;
      hung = 1'b1;
      return;
    end
    gnt_cycle = cycle;

    @(negedge clk);
    core_req = '0;
    bypass   = 1'b0;

    if (is_load) begin
      #1;
      waited = 0;
      while (!core_rsp.rvalid && waited < TIMEOUT_CYCLES) begin
        @(negedge clk);
        #1;
        waited++;
      end
      if (!core_rsp.rvalid) begin
        $display("%s: %s at %h got no read data in %0d cycles", test_name, op, addr,
                 TIMEOUT_CYCLES);
        test_errors++;
        errors++;
        hung = 1'b1;
        return;
      end
      check_value("read data", exp, core_rsp.rdata);
    end

    if (op == "LH") begin
      check_value("hit latency", 1, cycle - gnt_cycle);
      check_value("mem_req cycles", 0, req_cycles - req_before);
    end else if (is_load) begin
      check_value("line reads", 1, reads_seen - reads_before);
      check_value("bypass flag", is_bypass, last_bypass);
    end else begin
      check_value("word writes", 1, writes_seen - writes_before);
      check_value("bypass flag", is_bypass, last_bypass);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int            fd;
    int            code;
    string         tok;
    logic [1023:0] skipped;
    addr_t         addr;
    word_t         wdata;
    be_t           be;
    word_t         exp;

    rst_n    = 1'b0;
    bypass   = 1'b0;
    core_req = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("bench/dcache_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the operation file bench/dcache_testdata.txt");
      errors++;
    end else begin
      while (!hung && $fscanf(fd, "%s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          // drop the rest of a comment line
          code = $fgets(skipped, fd);
        end else if (tok == "TEST") begin
          if (in_test) begin
            report_test();
          end
          code = $fscanf(fd, "%s", test_name);
          test_ops    = 0;
          test_errors = 0;
          in_test     = 1'b1;
        end else if (tok == "LM" || tok == "LH" || tok == "ST" ||
                     tok == "BL" || tok == "BS") begin
          code = $fscanf(fd, "%h %h %h %h", addr, wdata, be, exp);
          if (code != 4) begin
            $display("%s: incomplete operation line for %s", test_name, tok);
            test_errors++;
            errors++;
          end else begin
            run_op(tok, addr, wdata, be, exp);
          end
        end else begin
          $display("%s: unknown opcode %s in the operation file", test_name, tok);
          test_errors++;
          errors++;
        end
      end
      if (in_test) begin
        report_test();
      end
      $fclose(fd);
    end

    $display("tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
    if (errors == 0 && !hung) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/dcache_testdata.txt
# columns: opcode, address, write data, byte enables, expected read data (hex)
# LM load miss, LH load hit, ST store, BL bypass load, BS bypass store; TEST names a group
TEST cold_miss
LM 1234 00000000 0 1234edcb
TEST hit_same_line
LH 1238 00000000 0 1238edc7
LH 1230 00000000 0 1230edcf
LH 1234 00000000 0 1234edcb
TEST store_merge
ST 123c aabbccdd 5 00000000
LH 123c 00000000 0 12bbeddd
ST 2000 0badf00d f 00000000
LM 2000 00000000 0 0badf00d
LM 4438 00000000 0 4438bbc7
LM 5530 00000000 0 5530aacf
LM 123c 00000000 0 12bbeddd
TEST round_robin
LM 3050 00000000 0 3050cfaf
LM 6154 00000000 0 61549eab
LH 3058 00000000 0 3058cfa7
LM 7258 00000000 0 72588da7
LH 615c 00000000 0 615c9ea3
LM 305c 00000000 0 305ccfa3
LH 7250 00000000 0 72508daf
LM 6150 00000000 0 61509eaf
TEST bypass
BL 8a04 00000000 0 8a0475fb
BS 8a08 11223344 3 00000000
BL 8a08 00000000 0 8a083344
LM 8a04 00000000 0 8a0475fb
LH 8a08 00000000 0 8a083344

//--- logic/cache_addr_pkg.sv
// data cache address and data types
// vector types for the address fields, the data word and the line

`default_nettype none

`include "cache_settings.svh"

package cache_addr_pkg;

  // byte address as seen on the core port
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;

  // address fields
  typedef logic [`CACHE_TAG_W-1:0]    tag_t;
  typedef logic [`CACHE_INDEX_W-1:0]  index_t;
  typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

  // data word and its byte enables
  typedef logic [`CACHE_WORD_W-1:0]   word_t;
  typedef logic [`CACHE_WORD_W/8-1:0] be_t;

  // full cache line, word 0 in the low bits
  typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_W-1:0] line_t;

  // one bit per way, one-hot where used
  typedef logic [`CACHE_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

//--- logic/cache_bus_pkg.sv
// data cache bus types
// core port and next-level port structs, controller state encoding

`default_nettype none

package cache_bus_pkg;

  // ----------------------------------------
  // core port
  // ----------------------------------------
  // held by the core until gnt
  typedef struct packed {
    logic                  valid;
    logic                  we;
    cache_addr_pkg::addr_t addr;
    cache_addr_pkg::word_t wdata;
    cache_addr_pkg::be_t   be;
  } core_req_t;

  // gnt and rvalid are single cycle strobes
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    cache_addr_pkg::word_t rdata;
  } core_rsp_t;

  // ----------------------------------------
  // next-level port
  // ----------------------------------------
  // held until mem_gnt_i, bypass marks uncached traffic
  typedef struct packed {
    logic                  valid;
    logic                  bypass;
    logic                  we;
    cache_addr_pkg::addr_t addr;
    cache_addr_pkg::word_t wdata;
    cache_addr_pkg::be_t   be;
  } mem_req_t;

  // whole aligned line, one pulse per read
  typedef struct packed {
    logic                  valid;
    cache_addr_pkg::line_t line;
  } mem_rsp_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    MEM_REQ,
    MEM_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- logic/cache_ctrl_fsm.sv
// data cache controller
// accepts core requests, resolves hit or miss, answers loads,
// writes stores into the hit way and through to the next level

`default_nettype none

`include "cache_settings.svh"

module cache_ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      bypass_i,
  // core port
  input  cache_bus_pkg::core_req_t  core_req_i,
  output cache_bus_pkg::core_rsp_t  core_rsp_o,
  // next-level port
  output cache_bus_pkg::mem_req_t   mem_req_o,
  input  logic                      mem_gnt_i,
  input  cache_bus_pkg::mem_rsp_t   mem_rsp_i,
  // tag lookup
  output cache_addr_pkg::index_t    lookup_index_o,
  output cache_addr_pkg::tag_t      lookup_tag_o,
  input  cache_addr_pkg::way_mask_t hit_way_i,
  input  cache_addr_pkg::way_mask_t victim_way_i,
  // line store read
  input  cache_addr_pkg::line_t     rd_line_i,
  // refill write
  output logic                      fill_o,
  output cache_addr_pkg::way_mask_t fill_way_o,
  output cache_addr_pkg::index_t    fill_index_o,
  output cache_addr_pkg::tag_t      fill_tag_o,
  output cache_addr_pkg::line_t     fill_line_o,
  // store write
  output logic                      wr_o,
  output cache_addr_pkg::way_mask_t wr_way_o,
  output cache_addr_pkg::index_t    wr_index_o,
  output cache_addr_pkg::offset_t   wr_offset_o,
  output cache_addr_pkg::word_t     wr_word_o,
  output cache_addr_pkg::be_t       wr_be_o
);

  import cache_addr_pkg::*;
  import cache_bus_pkg::*;

  // request as accepted from the core
  typedef struct packed {
    logic  we;
    logic  bypass;
    addr_t addr;
    word_t wdata;
    be_t   be;
  } saved_req_t;

  ctrl_state_e state_d, state_q;
  saved_req_t  req_d, req_q;
  way_mask_t   hit_way_d, hit_way_q;

  // new request taken this cycle
  logic accept;
  // next-level request strobe
  logic mem_valid;

  // ----------------------------------------
  // address field helpers
  // ----------------------------------------
  function automatic tag_t addr_tag(input addr_t a);
    return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  endfunction

  function automatic index_t addr_index(input addr_t a);
    return a[`CACHE_ADDR_W-`CACHE_TAG_W-1 -: `CACHE_INDEX_W];
  endfunction

  function automatic offset_t addr_offset(input addr_t a);
    return a[`CACHE_ADDR_W-`CACHE_TAG_W-`CACHE_INDEX_W-1 -: `CACHE_OFFSET_W];
  endfunction

  // word of a line by offset
  function automatic word_t word_sel(input line_t line, input offset_t off);
    return line[int'(off) * `CACHE_WORD_W +: `CACHE_WORD_W];
  endfunction

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  always_comb begin : ctrl_comb
    state_d    = state_q;
    req_d      = req_q;
    hit_way_d  = hit_way_q;
    accept     = 1'b0;
    mem_valid  = 1'b0;
    fill_o     = 1'b0;
    wr_o       = 1'b0;
    core_rsp_o = '0;

    case (state_q)
      IDLE: begin
        if (core_req_i.valid) begin
          accept = 1'b1;
          // loads are granted on acceptance, stores on completion
          core_rsp_o.gnt = ~core_req_i.we;
          // uncached traffic skips the lookup
          state_d = bypass_i ? MEM_REQ : LOOKUP;
        end
      end

      LOOKUP: begin
        if (|hit_way_i) begin
          if (req_q.we) begin
            // remember the way for the store write
            hit_way_d = hit_way_i;
            state_d   = STORE_WRITE;
          end else begin
            core_rsp_o.rvalid = 1'b1;
            core_rsp_o.rdata  = word_sel(rd_line_i, addr_offset(req_q.addr));
            state_d           = IDLE;
            // hit under hit, take the next cached load right away
            if (core_req_i.valid && !core_req_i.we && !bypass_i) begin
              accept         = 1'b1;
              core_rsp_o.gnt = 1'b1;
              state_d        = LOOKUP;
            end
          end
        end else begin
          // load refill or store miss, no allocate on store
          state_d = MEM_REQ;
        end
      end

      STORE_WRITE: begin
        // line update and write-through start together
        wr_o      = 1'b1;
        mem_valid = 1'b1;
        if (mem_gnt_i) begin
          core_rsp_o.gnt = 1'b1;
          state_d        = IDLE;
        end else begin
          state_d = MEM_REQ;
        end
      end

      MEM_REQ: begin
        mem_valid = 1'b1;
        if (mem_gnt_i) begin
          if (req_q.we) begin
            // the grant ends a store
            core_rsp_o.gnt = 1'b1;
            state_d        = IDLE;
          end else begin
            state_d = MEM_WAIT;
          end
        end
      end

      MEM_WAIT: begin
        if (mem_rsp_i.valid) begin
          // critical word straight from the returned line
          core_rsp_o.rvalid = 1'b1;
          core_rsp_o.rdata  = word_sel(mem_rsp_i.line, addr_offset(req_q.addr));
          fill_o            = ~req_q.bypass;
          state_d           = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // capture the incoming request
    if (accept) begin
      req_d.we     = core_req_i.we;
      req_d.bypass = bypass_i;
      req_d.addr   = core_req_i.addr;
      req_d.wdata  = core_req_i.wdata;
      req_d.be     = core_req_i.be;
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      req_q     <= '0;
      hit_way_q <= '0;
    end else begin
      state_q   <= state_d;
      req_q     <= req_d;
      hit_way_q <= hit_way_d;
    end
  end

  // lookup follows a new request, otherwise stays on the saved one
  assign lookup_index_o = accept ? addr_index(core_req_i.addr) : addr_index(req_q.addr);
  assign lookup_tag_o   = addr_tag(req_q.addr);

  // next-level request from the saved fields
  always_comb begin
    mem_req_o.valid  = mem_valid;
    mem_req_o.bypass = req_q.bypass;
    mem_req_o.we     = req_q.we;
    mem_req_o.addr   = req_q.addr;
    mem_req_o.wdata  = req_q.wdata;
    mem_req_o.be     = req_q.be;
  end

  // refill goes to the current victim
  assign fill_way_o   = victim_way_i;
  assign fill_index_o = addr_index(req_q.addr);
  assign fill_tag_o   = addr_tag(req_q.addr);
  assign fill_line_o  = mem_rsp_i.line;

  // store into the way that hit
  assign wr_way_o    = hit_way_q;
  assign wr_index_o  = addr_index(req_q.addr);
  assign wr_offset_o = addr_offset(req_q.addr);
  assign wr_word_o   = req_q.wdata;
  assign wr_be_o     = req_q.be;

endmodule

`default_nettype wire

//--- logic/cache_settings.svh
// data cache sizing
// two-way set-associative, write-through, word aligned accesses
// all widths of the design derive from the values below

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_WAYS       2
`define CACHE_SETS       16
`define CACHE_LINE_WORDS 4

// datapath widths
`define CACHE_WORD_W     32
`define CACHE_ADDR_W     16

// ----------------------------------------
// derived address split
// ----------------------------------------
// word within a line
`define CACHE_OFFSET_W   $clog2(`CACHE_LINE_WORDS)
// set select
`define CACHE_INDEX_W    $clog2(`CACHE_SETS)
// what is left above index, offset and the two byte bits
`define CACHE_TAG_W      (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W - $clog2(`CACHE_WORD_W / 8))

`endif

//--- logic/dcache_top.sv
// data cache top level
// tag lookup and line store on a shared set index, driven by the controller

`default_nettype none

module dcache_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     bypass_i,
  // core port
  input  cache_bus_pkg::core_req_t core_req_i,
  output cache_bus_pkg::core_rsp_t core_rsp_o,
  // next-level port
  output cache_bus_pkg::mem_req_t  mem_req_o,
  input  logic                     mem_gnt_i,
  input  cache_bus_pkg::mem_rsp_t  mem_rsp_i
);

  import cache_addr_pkg::*;

  // lookup
  index_t    lookup_index;
  tag_t      lookup_tag;
  way_mask_t hit_way;
  way_mask_t victim_way;
  line_t     rd_line;

  // refill
  logic      fill;
  way_mask_t fill_way;
  index_t    fill_index;
  tag_t      fill_tag;
  line_t     fill_line;

  // store write
  logic      wr;
  way_mask_t wr_way;
  index_t    wr_index;
  offset_t   wr_offset;
  word_t     wr_word;
  be_t       wr_be;

  tag_lookup i_tag_lookup (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .fill_i         (fill),
    .fill_way_i     (fill_way),
    .fill_index_i   (fill_index),
    .fill_tag_i     (fill_tag),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way)
  );

  line_store i_line_store (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_index_i (lookup_index),
    .rd_line_o      (rd_line),
    .fill_i         (fill),
    .fill_way_i     (fill_way),
    .fill_index_i   (fill_index),
    .fill_line_i    (fill_line),
    .wr_i           (wr),
    .wr_way_i       (wr_way),
    .wr_index_i     (wr_index),
    .wr_offset_i    (wr_offset),
    .wr_word_i      (wr_word),
    .wr_be_i        (wr_be),
    .hit_way_i      (hit_way)
  );

  cache_ctrl_fsm i_cache_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bypass_i       (bypass_i),
    .core_req_i     (core_req_i),
    .core_rsp_o     (core_rsp_o),
    .mem_req_o      (mem_req_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rsp_i      (mem_rsp_i),
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .rd_line_i      (rd_line),
    .fill_o         (fill),
    .fill_way_o     (fill_way),
    .fill_index_o   (fill_index),
    .fill_tag_o     (fill_tag),
    .fill_line_o    (fill_line),
    .wr_o           (wr),
    .wr_way_o       (wr_way),
    .wr_index_o     (wr_index),
    .wr_offset_o    (wr_offset),
    .wr_word_o      (wr_word),
    .wr_be_o        (wr_be)
  );

endmodule

`default_nettype wire

//--- logic/line_store.sv
// line storage for the two-way data cache
// registered read of the looked-up set, way select by hit vector,
// full line refill or byte-enabled single word store

`default_nettype none

`include "cache_settings.svh"

module line_store (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // read side
  input  cache_addr_pkg::index_t    lookup_index_i,
  output cache_addr_pkg::line_t     rd_line_o,
  // refill write
  input  logic                      fill_i,
  input  cache_addr_pkg::way_mask_t fill_way_i,
  input  cache_addr_pkg::index_t    fill_index_i,
  input  cache_addr_pkg::line_t     fill_line_i,
  // store write
  input  logic                      wr_i,
  input  cache_addr_pkg::way_mask_t wr_way_i,
  input  cache_addr_pkg::index_t    wr_index_i,
  input  cache_addr_pkg::offset_t   wr_offset_i,
  input  cache_addr_pkg::word_t     wr_word_i,
  input  cache_addr_pkg::be_t       wr_be_i,
  // way select for the read mux
  input  cache_addr_pkg::way_mask_t hit_way_i
);

  import cache_addr_pkg::*;

  // line array per way
  line_t data_q [`CACHE_WAYS][`CACHE_SETS];

  // lines of all ways of the looked-up set
  line_t [`CACHE_WAYS-1:0] rd_lines_q;

  // ----------------------------------------
  // read port
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_lines_q <= '0;
    end else begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        rd_lines_q[w] <= data_q[w][lookup_index_i];
      end
    end
  end

  // pick the hitting way, zero on a miss
  always_comb begin
    rd_line_o = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hit_way_i[w]) begin
        rd_line_o = rd_lines_q[w];
      end
    end
  end

  // ----------------------------------------
  // write port
  // ----------------------------------------
  // refill has priority, the controller never issues both at once
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (fill_i && fill_way_i[w]) begin
        data_q[w][fill_index_i] <= fill_line_i;
      end else if (wr_i && wr_way_i[w]) begin
        // only the enabled bytes of the addressed word
        for (int b = 0; b < `CACHE_WORD_W / 8; b++) begin
          if (wr_be_i[b]) begin
            data_q[w][wr_index_i][int'(wr_offset_i) * `CACHE_WORD_W + b * 8 +: 8] <=
                wr_word_i[b * 8 +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/tag_lookup.sv
// tag lookup for the two-way data cache
// valid and tag arrays per way, one-hot hit detection,
// round-robin victim choice shared by all sets

`default_nettype none

`include "cache_settings.svh"

module tag_lookup (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // lookup side
  input  cache_addr_pkg::index_t    lookup_index_i,
  input  cache_addr_pkg::tag_t      lookup_tag_i,
  // refill side
  input  logic                      fill_i,
  input  cache_addr_pkg::way_mask_t fill_way_i,
  input  cache_addr_pkg::index_t    fill_index_i,
  input  cache_addr_pkg::tag_t      fill_tag_i,
  // results
  output cache_addr_pkg::way_mask_t hit_way_o,
  output cache_addr_pkg::way_mask_t victim_way_o
);

  import cache_addr_pkg::*;

  // tag storage per way and set
  tag_t tag_q [`CACHE_WAYS][`CACHE_SETS];

  // valid bit per way and set
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;

  // set of the request now in lookup
  index_t index_q;

  // round-robin victim that toggles on every refill
  logic victim_q;

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      index_q  <= '0;
      victim_q <= 1'b0;
    end else begin
      // index follows the controller every cycle
      index_q <= lookup_index_i;
      if (fill_i) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          if (fill_way_i[w]) begin
            valid_q[w][fill_index_i] <= 1'b1;
          end
        end
        // next refill goes to the other way
        victim_q <= ~victim_q;
      end
    end
  end

  // tag write on refill
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (fill_i && fill_way_i[w]) begin
        tag_q[w][fill_index_i] <= fill_tag_i;
      end
    end
  end

  // ----------------------------------------
  // hit detection
  // ----------------------------------------
  // compare all ways of the registered set against the saved tag
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_way_o[w] = valid_q[w][index_q] && (tag_q[w][index_q] == lookup_tag_i);
    end
  end

  // one-hot form of the victim bit
  assign victim_way_o = way_mask_t'(1) << victim_q;

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/cache_addr_pkg.sv
logic/cache_bus_pkg.sv
logic/tag_lookup.sv
logic/line_store.sv
logic/cache_ctrl_fsm.sv
logic/dcache_top.sv
bench/dcache_tb.sv
